// ==== dv/pdp8_assertions.sv ====
// Concurrent checks on PDP-8 core control, bound into every pdp8_core instance by the bind below
`timescale 1ns/1ps
`default_nettype none

module pdp8_assertions import pdp8_pkg::*; (
	input logic     i_clk,
	input logic     i_reset,
	input logic     i_load_we,                     // Load port strobe
	input logic     i_start,                       // Run pulse
	input logic     i_halted,
	input addr_t    i_pc,
	input mem_req_t i_mem_req                      // Sequencer to memory
);

	// Memory is written while halted only through the load port
	a_halt_write: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_halted && i_mem_req.we) |-> i_load_we)
		else $error("Memory write while halted without a load strobe");

	// Halted is held until a start pulse
	a_halt_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_halted && !i_start) |=> i_halted)
		else $error("Core left the halted state without a start pulse");

	// PC frozen while halted and not starting
	a_pc_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_halted && !i_start) |=> $stable(i_pc))
		else $error("PC changed while the core was halted");

endmodule

bind pdp8_core pdp8_assertions u_assertions (
	.i_clk     (i_clk),
	.i_reset   (i_reset),
	.i_load_we (i_load_we),
	.i_start   (i_start),
	.i_halted  (o_halted),
	.i_pc      (o_pc),
	.i_mem_req (mem_req)
);

`default_nettype wire

// ==== dv/pdp8_tb.sv ====
// Directed testbench for the PDP-8 core, loads short programs, runs each to HLT, checks AC, link, PC
`timescale 1ns/1ps
`default_nettype none

module pdp8_tb import pdp8_pkg::*; ();

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_TESTS    = 5;
	localparam int TEST_CYCLES  = 400;             // Load, run and check budget per test

	logic       clk;
	logic       reset;
	logic       load_we;
	addr_t      load_addr;
	word_t      load_data;
	logic       start;
	addr_t      start_pc;
	word_t      switches;
	logic       halted;
	addr_t      pc;
	acc_state_t acc;

	word_t      prog [$];                          // Image for the next load_program
	int         n_checks;
	int         n_errors;

	pdp8_core dut (
		.i_clk       (clk),
		.i_reset     (reset),
		.i_load_we   (load_we),
		.i_load_addr (load_addr),
		.i_load_data (load_data),
		.i_start     (start),
		.i_start_pc  (start_pc),
		.i_switches  (switches),
		.o_halted    (halted),
		.o_pc        (pc),
		.o_acc       (acc)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Watchdog sized from the test budget
	initial begin
		#((RESET_CYCLES + NUM_TESTS * TEST_CYCLES) * CLK_PERIOD);
		$display("Timeout, the core did not reach HLT within the cycle budget");
		$display("Something failed");
		$finish;
	end

	// ************************************************************
	// Compare tasks
	// ************************************************************
	task automatic check_word(input string name, input word_t exp, input word_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("Error %s AC: expected %04o, actual %04o", name, exp, act);
		end
	endtask

	task automatic check_link(input string name, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("Error %s link: expected %0b, actual %0b", name, exp, act);
		end
	endtask

	task automatic check_pc(input string name, input addr_t exp, input addr_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("Error %s PC: expected %04o, actual %04o", name, exp, act);
		end
	endtask

	// Link in bit 12, AC below it
	task automatic check_result(input string name, input logic [12:0] lac, input addr_t exp_pc);
		check_word(name, lac[11:0], acc.ac);
		check_link(name, lac[12], acc.link);
		check_pc(name, exp_pc, pc);
	endtask

	// ************************************************************
	// Load and run
	// ************************************************************
	task automatic load_word(input addr_t addr, input word_t data);
		@(negedge clk);
		load_we   = 1'b1;                          // Written on the next rising edge
		load_addr = addr;
		load_data = data;
	endtask

	task automatic load_program(input addr_t origin);
		foreach (prog[i]) begin
			load_word(origin + addr_t'(i), prog[i]);
		end
	endtask

	task automatic run_program(input addr_t entry);
		@(negedge clk);
		load_we  = 1'b0;
		start    = 1'b1;
		start_pc = entry;
		@(negedge clk);
		start = 1'b0;
		while (!halted) begin
			@(negedge clk);                        // Poll until HLT
		end
	endtask

	// ************************************************************
	// Directed tests
	// ************************************************************
	task automatic and_tad_dca();
		word_t       a;
		word_t       b;
		word_t       c;
		logic [12:0] lac;
		a   = word_t'($urandom);
		b   = word_t'($urandom);
		c   = word_t'($urandom);
		lac = {1'b0, a & b} + {1'b0, c};           // DCA then TAD gives the same word back
		prog = '{12'o7300, 12'o1040, 12'o0041, 12'o1042, 12'o3043, 12'o1043, 12'o7402};
		load_program(RESET_PC);
		load_word(12'o0040, a);
		load_word(12'o0041, b);
		load_word(12'o0042, c);
		run_program(RESET_PC);
		check_result("mem_ref", lac, 12'o0207);
	endtask

	task automatic tad_carry_link();
		word_t       x;
		word_t       y;
		logic [12:0] lac;
		x    = word_t'($urandom) | 12'o4000;       // Both sign bits set, sum overflows
		y    = word_t'($urandom) | 12'o4000;
		prog = '{12'o7300, 12'o1040, 12'o1041, 12'o7402, 12'o7200, 12'o1040, 12'o1041, 12'o7402};
		load_program(RESET_PC);
		load_word(12'o0040, x);
		load_word(12'o0041, y);
		lac = {1'b0, x} + {1'b0, y};
		run_program(RESET_PC);
		check_result("tad_carry_set", lac, 12'o0204);
		lac = {lac[12], 12'o0000} + {1'b0, x} + {1'b0, y};  // CLA keeps the link
		run_program(12'o0204);
		check_result("tad_carry_flip", lac, 12'o0210);
	endtask

	task automatic isz_loop();
		int n;
		n    = 1 + ($urandom % 20);
		prog = '{12'o7300, 12'o7001, 12'o2040, 12'o5201, 12'o7402};  // IAC, ISZ, JMP back
		load_program(RESET_PC);
		load_word(12'o0040, word_t'(4096 - n));    // Counter at minus N
		run_program(RESET_PC);
		check_result("isz_loop", {1'b0, word_t'(n)}, 12'o0205);
	endtask

	task automatic jms_indirect_return();
		word_t       v1;
		word_t       v2;
		logic [12:0] lac;
		v1   = word_t'($urandom);
		v2   = word_t'($urandom);
		lac  = {1'b0, v1} + {1'b0, v2};
		prog = '{12'o7300, 12'o4250, 12'o4440, 12'o7402};  // JMS direct, then JMS I via 0040
		load_program(RESET_PC);
		prog = '{12'o0000, 12'o1041, 12'o5650};    // Returns through current-page pointer
		load_program(12'o0250);
		prog = '{12'o0000, 12'o1042, 12'o5660};
		load_program(12'o0260);
		load_word(12'o0040, 12'o0260);             // Page-zero pointer
		load_word(12'o0041, v1);
		load_word(12'o0042, v2);
		run_program(RESET_PC);
		check_result("subroutine", lac, 12'o0204);
	endtask

	task automatic microinstructions();
		word_t       r;
		word_t       sw;
		logic [12:0] lac;
		r  = word_t'($urandom);
		sw = word_t'($urandom);
		@(negedge clk);
		switches = sw;
		prog = '{12'o7300, 12'o1040, 12'o7004, 12'o7402,  // Load r and rotate left
		         12'o7012, 12'o7402, 12'o7060, 12'o7402,  // RTR, then CMA CML
		         12'o7404, 12'o7402,                      // OSR
		         12'o7300, 12'o7440, 12'o7001, 12'o7450, 12'o7001, 12'o7440,  // Zero tests
		         12'o7001, 12'o7450, 12'o7001, 12'o7500, 12'o7001, 12'o7510,
		         12'o7001, 12'o7040, 12'o7500, 12'o7001, 12'o7510, 12'o7001,  // AC negative
		         12'o7420, 12'o7001, 12'o7430, 12'o7001, 12'o7020, 12'o7420,  // Link tests
		         12'o7001, 12'o7430, 12'o7001, 12'o7402};
		load_program(RESET_PC);
		load_word(12'o0040, r);
		lac = {1'b0, r};
		lac = {lac[11:0], lac[12]};                // One place left through the link
		run_program(RESET_PC);
		check_result("rotate_left", lac, 12'o0204);
		lac = {lac[1:0], lac[12:2]};               // Two places right
		run_program(12'o0204);
		check_result("rotate_right_two", lac, 12'o0206);
		lac = ~lac;
		run_program(12'o0206);
		check_result("complement", lac, 12'o0210);
		lac[11:0] = lac[11:0] | sw;
		run_program(12'o0210);
		check_result("osr", lac, 12'o0212);
		run_program(12'o0212);                     // Each wrong skip shifts the IAC count
		check_result("skips", 13'o17777, 12'o0246);
	endtask

	// ************************************************************
	// Main sequence
	// ************************************************************
	initial begin
		void'($urandom(32'h0859_3cd8));
		n_checks  = 0;
		n_errors  = 0;
		reset     = 1'b1;
		load_we   = 1'b0;
		load_addr = '0;
		load_data = '0;
		start     = 1'b0;
		start_pc  = '0;
		switches  = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		and_tad_dca();
		tad_carry_link();
		isz_loop();
		jms_indirect_return();
		microinstructions();
		$display("Checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== pdp8.f ====
src/pdp8_pkg.sv
src/pdp8_memory.sv
src/pdp8_operate.sv
src/pdp8_accumulator.sv
src/pdp8_sequencer.sv
src/pdp8_core.sv
dv/pdp8_assertions.sv
dv/pdp8_tb.sv

// ==== src/pdp8_accumulator.sv ====
// PDP-8 AC and link registers, updated by memory-reference results or operate microinstructions
`timescale 1ns/1ps
`default_nettype none

module pdp8_accumulator import pdp8_pkg::*; (
	input  logic       i_clk,
	input  logic       i_reset,
	input  acc_op_e    i_acc_op,                   // Update select from sequencer
	input  word_t      i_operand,                  // Memory word for AND and TAD
	input  word_t      i_ir,                       // Instruction for operate decode
	input  word_t      i_switches,                 // Switch register for OSR
	output acc_state_t o_acc,                      // Registered link and AC
	output logic       o_skip,                     // From operate unit
	output logic       o_halt_req                  // From operate unit
);

	acc_state_t      acc_q;
	acc_state_t      op_acc;                       // Operate result
	logic [0:WORD_W] tad_sum;                      // Link and AC plus operand

	// 13-bit add, a carry out of the AC flips the link
	assign tad_sum = {acc_q.link, acc_q.ac} + {1'b0, i_operand};

	pdp8_operate u_operate (
		.i_ir       (i_ir),
		.i_acc      (acc_q),
		.i_switches (i_switches),
		.o_acc      (op_acc),
		.o_skip     (o_skip),
		.o_halt_req (o_halt_req)
	);

	// ************************************************************
	// AC and link
	// ************************************************************
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			acc_q <= '0;                           // AC and link cleared
		end else begin
			case (i_acc_op)
				ACC_AND: begin
					acc_q.ac <= acc_q.ac & i_operand;  // Link kept
				end
				ACC_TAD: begin
					acc_q.link <= tad_sum[0];
					acc_q.ac   <= tad_sum[1:WORD_W];
				end
				ACC_CLEAR: begin
					acc_q.ac <= '0;                // DCA after the store
				end
				ACC_OPERATE: begin
					acc_q <= op_acc;
				end
				default: begin
					acc_q <= acc_q;                // ACC_NONE holds
				end
			endcase
		end
	end

	assign o_acc = acc_q;

endmodule

`default_nettype wire

// ==== src/pdp8_core.sv ====
// PDP-8 processor top, joins sequencer, AC unit and 4K memory, loaded and started while halted
`timescale 1ns/1ps
`default_nettype none

module pdp8_core import pdp8_pkg::*; (
	input  logic       i_clk,
	input  logic       i_reset,
	input  logic       i_load_we,                  // Memory load strobe
	input  addr_t      i_load_addr,
	input  word_t      i_load_data,
	input  logic       i_start,                    // Run pulse
	input  addr_t      i_start_pc,
	input  word_t      i_switches,                 // Switch register
	output logic       o_halted,
	output addr_t      o_pc,
	output acc_state_t o_acc                       // Link and AC
);

	// ************************************************************
	// Internal nets
	// ************************************************************
	mem_req_t mem_req;
	word_t    rdata;
	acc_op_e  acc_op;
	word_t    operand;
	word_t    ir;
	logic     skip;
	logic     halt_req;

	pdp8_sequencer u_sequencer (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_load_we   (i_load_we),
		.i_load_addr (i_load_addr),
		.i_load_data (i_load_data),
		.i_start     (i_start),
		.i_start_pc  (i_start_pc),
		.i_rdata     (rdata),
		.i_skip      (skip),
		.i_halt_req  (halt_req),
		.i_acc       (o_acc),
		.o_mem_req   (mem_req),
		.o_acc_op    (acc_op),
		.o_operand   (operand),
		.o_ir        (ir),
		.o_halted    (o_halted),
		.o_pc        (o_pc)
	);

	pdp8_accumulator u_accumulator (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_acc_op   (acc_op),
		.i_operand  (operand),
		.i_ir       (ir),
		.i_switches (i_switches),
		.o_acc      (o_acc),
		.o_skip     (skip),
		.o_halt_req (halt_req)
	);

	pdp8_memory u_memory (
		.i_clk   (i_clk),
		.i_req   (mem_req),
		.o_rdata (rdata)
	);

endmodule

`default_nettype wire

// ==== src/pdp8_memory.sv ====
// PDP-8 core memory, 4K words, written by the sequencer or load port, read one cycle late
`timescale 1ns/1ps
`default_nettype none

module pdp8_memory import pdp8_pkg::*; (
	input  logic     i_clk,
	input  mem_req_t i_req,                        // Address, strobe and data from sequencer
	output word_t    o_rdata                       // Registered read word
);

	// ************************************************************
	// Storage
	// ************************************************************
	word_t mem [0:MEM_WORDS-1];                    // 4K by 12 bits

	// Write port
	always_ff @(posedge i_clk) begin
		if (i_req.we) begin
			mem[i_req.addr] <= i_req.wdata;        // Store on strobe
		end
	end

	// Read port, sampled every cycle
	// A write to the same address returns the old word
	always_ff @(posedge i_clk) begin
		o_rdata <= mem[i_req.addr];                // Valid in the following state
	end

endmodule

`default_nettype wire

// ==== src/pdp8_operate.sv ====
// Combinational PDP-8 operate microinstructions, gives next AC and link plus skip and halt
`timescale 1ns/1ps
`default_nettype none

module pdp8_operate import pdp8_pkg::*; (
	input  word_t      i_ir,                       // Current instruction word
	input  acc_state_t i_acc,                      // Present link and AC
	input  word_t      i_switches,                 // Front panel switch register
	output acc_state_t o_acc,                      // Link and AC after the microinstructions
	output logic       o_skip,                     // Skip next instruction
	output logic       o_halt_req                  // HLT seen
);

	opcode_e         opcode;
	logic            is_grp1;
	logic            is_grp2;
	word_t           g1_ac;                        // After clear, complement, increment
	logic            g1_link;
	logic [0:WORD_W] g1_lac;                       // Link in bit 0, AC behind it
	word_t           g2_ac;
	logic            cond_any;                     // OR of the selected skip tests

	assign opcode  = opcode_e'(i_ir[0:2]);
	assign is_grp1 = (opcode == OPR) && !i_ir[BIT_GROUP];
	assign is_grp2 = (opcode == OPR) && i_ir[BIT_GROUP] && !i_ir[BIT_GROUP3];

	// ************************************************************
	// Group 1
	// ************************************************************
	always_comb begin
		g1_ac   = i_acc.ac;
		g1_link = i_acc.link;
		if (i_ir[G1_CLA]) g1_ac = '0;              // Step 1
		if (i_ir[G1_CLL]) g1_link = 1'b0;
		if (i_ir[G1_CMA]) g1_ac = ~g1_ac;          // Step 2
		if (i_ir[G1_CML]) g1_link = ~g1_link;
		if (i_ir[G1_IAC]) begin
			{g1_link, g1_ac} = {g1_link, g1_ac} + 1'b1;  // Step 3, carry into link
		end
		g1_lac = {g1_link, g1_ac};
		// Step 4, 13-bit rotate through the link
		if (i_ir[G1_RAR]) begin
			if (i_ir[G1_TWICE]) g1_lac = {g1_lac[WORD_W-1:WORD_W], g1_lac[0:WORD_W-2]};
			else                g1_lac = {g1_lac[WORD_W], g1_lac[0:WORD_W-1]};
		end else if (i_ir[G1_RAL]) begin
			if (i_ir[G1_TWICE]) g1_lac = {g1_lac[2:WORD_W], g1_lac[0:1]};
			else                g1_lac = {g1_lac[1:WORD_W], g1_lac[0]};
		end
	end

	// ************************************************************
	// Group 2
	// ************************************************************
	// Tests look at the AC before CLA
	assign cond_any = (i_ir[G2_SMA] && i_acc.ac[0])
	               || (i_ir[G2_SZA] && (i_acc.ac == '0))
	               || (i_ir[G2_SNL] && i_acc.link);

	always_comb begin
		g2_ac = i_ir[G2_CLA] ? '0 : i_acc.ac;      // CLA first
		if (i_ir[G2_OSR]) g2_ac = g2_ac | i_switches;  // Then OR switches
	end

	// Output select, group 3 and non-OPR words pass the state through
	always_comb begin
		o_acc      = i_acc;
		o_skip     = 1'b0;
		o_halt_req = 1'b0;
		if (is_grp1) begin
			o_acc.link = g1_lac[0];
			o_acc.ac   = g1_lac[1:WORD_W];
		end else if (is_grp2) begin
			o_acc.ac   = g2_ac;                    // Link untouched in group 2
			o_skip     = i_ir[G2_REV] ^ cond_any;  // Reversed with nothing selected is SKP
			o_halt_req = i_ir[G2_HLT];
		end
	end

endmodule

`default_nettype wire

// ==== src/pdp8_pkg.sv ====
// Shared PDP-8 word types, opcodes, sequencer states and instruction bit positions
`default_nettype none

package pdp8_pkg;

	// ************************************************************
	// Sizes
	// ************************************************************
	localparam int WORD_W    = 12;                 // Machine word
	localparam int ADDR_W    = 12;                 // 4K address space
	localparam int MEM_WORDS = 4096;               // Core memory depth
	localparam int PAGE_W    = 5;                  // Page number bits
	localparam int OFFSET_W  = 7;                  // Word offset within page

	typedef logic [0:WORD_W-1] word_t;             // Bit 0 is the MSB
	typedef logic [0:ADDR_W-1] addr_t;             // Page in 0..4, offset in 5..11

	localparam addr_t RESET_PC = 12'o0200;         // Conventional program origin

	// Major opcode in IR bits 0..2
	typedef enum logic [2:0] {
		AND, TAD, ISZ, DCA, JMS, JMP, IOT, OPR
	} opcode_e;

	// Instruction cycle states
	typedef enum logic [2:0] {
		S_HALT, S_FETCH, S_DECODE, S_DEFER, S_READ, S_EXEC, S_WRITE
	} seq_state_e;

	typedef struct packed {
		logic  we;                                 // Write strobe
		addr_t addr;                               // Read or write address
		word_t wdata;                              // Write data
	} mem_req_t;

	// Accumulator register update select
	typedef enum logic [2:0] {
		ACC_NONE, ACC_AND, ACC_TAD, ACC_CLEAR, ACC_OPERATE
	} acc_op_e;

	typedef struct packed {
		logic  link;                               // L, top bit of the 13-bit pair
		word_t ac;                                 // Accumulator
	} acc_state_t;

	// ************************************************************
	// Instruction bit positions
	// ************************************************************
	localparam int BIT_INDIRECT = 3;               // MRI defer bit
	localparam int BIT_CURPAGE  = 4;               // MRI current page bit
	localparam int BIT_GROUP    = 3;               // OPR group 1 vs 2/3
	localparam int BIT_GROUP3   = 11;              // With BIT_GROUP set, selects group 3

	localparam int G1_CLA   = 4;
	localparam int G1_CLL   = 5;
	localparam int G1_CMA   = 6;
	localparam int G1_CML   = 7;
	localparam int G1_RAR   = 8;
	localparam int G1_RAL   = 9;
	localparam int G1_TWICE = 10;                  // RTR / RTL
	localparam int G1_IAC   = 11;

	localparam int G2_CLA = 4;
	localparam int G2_SMA = 5;                     // SPA when reversed
	localparam int G2_SZA = 6;                     // SNA when reversed
	localparam int G2_SNL = 7;                     // SZL when reversed
	localparam int G2_REV = 8;                     // Sense reverse, AND of inverted tests
	localparam int G2_OSR = 9;
	localparam int G2_HLT = 10;

endpackage

`default_nettype wire

// ==== src/pdp8_sequencer.sv ====
// PDP-8 instruction sequencer with PC, IR and effective address, runs one instruction at a time
`timescale 1ns/1ps
`default_nettype none

module pdp8_sequencer import pdp8_pkg::*; (
	input  logic       i_clk,
	input  logic       i_reset,
	input  logic       i_load_we,                  // Load port, honoured only when halted
	input  addr_t      i_load_addr,
	input  word_t      i_load_data,
	input  logic       i_start,                    // One-cycle run pulse
	input  addr_t      i_start_pc,
	input  word_t      i_rdata,                    // Memory word, one cycle after address
	input  logic       i_skip,                     // Operate skip
	input  logic       i_halt_req,                 // Operate HLT
	input  acc_state_t i_acc,                      // For DCA store data
	output mem_req_t   o_mem_req,
	output acc_op_e    o_acc_op,
	output word_t      o_operand,
	output word_t      o_ir,
	output logic       o_halted,
	output addr_t      o_pc
);

	seq_state_e state_q;
	addr_t      pc_q;                              // Address of current instruction
	word_t      ir_q;
	addr_t      ea_q;                              // Effective address
	word_t      isz_q;                             // Incremented ISZ word for write-back

	word_t      cur_ir;                            // IR as seen this cycle
	opcode_e    opcode;
	addr_t      ea_direct;                         // Page zero or current page address
	addr_t      pc_inc;
	addr_t      pc_skip;
	seq_state_e after_ea;                          // Where to go once EA is known

	// Instruction word arrives on i_rdata in S_DECODE
	assign cur_ir    = (state_q == S_DECODE) ? i_rdata : ir_q;
	assign opcode    = opcode_e'(cur_ir[0:2]);
	assign ea_direct = cur_ir[BIT_CURPAGE]
	                 ? {pc_q[0:PAGE_W-1], cur_ir[WORD_W-OFFSET_W:WORD_W-1]}
	                 : {{PAGE_W{1'b0}}, cur_ir[WORD_W-OFFSET_W:WORD_W-1]};
	assign pc_inc    = pc_q + 12'd1;
	assign pc_skip   = pc_q + 12'd2;

	always_comb begin
		case (opcode)
			AND, TAD, ISZ: after_ea = S_READ;      // Need the operand
			DCA, JMS:      after_ea = S_WRITE;     // Store only
			default:       after_ea = S_FETCH;     // JMP
		endcase
	end

	// ************************************************************
	// Memory request
	// ************************************************************
	always_comb begin
		o_mem_req.we    = 1'b0;
		o_mem_req.addr  = pc_q;                    // Fetch address by default
		o_mem_req.wdata = i_acc.ac;
		case (state_q)
			S_HALT: begin
				o_mem_req.we    = i_load_we;       // Load port owns memory
				o_mem_req.addr  = i_load_addr;
				o_mem_req.wdata = i_load_data;
			end
			S_DECODE: o_mem_req.addr = ea_direct;  // Pointer read for S_DEFER
			S_READ:   o_mem_req.addr = ea_q;
			S_WRITE: begin
				o_mem_req.we   = 1'b1;
				o_mem_req.addr = ea_q;
				case (opcode)
					JMS:     o_mem_req.wdata = pc_inc;  // Return address
					ISZ:     o_mem_req.wdata = isz_q;
					default: o_mem_req.wdata = i_acc.ac; // DCA
				endcase
			end
			default: ;
		endcase
	end

	// Accumulator control
	always_comb begin
		o_acc_op = ACC_NONE;
		case (state_q)
			S_DECODE: if (opcode == OPR) o_acc_op = ACC_OPERATE;
			S_EXEC: begin
				if (opcode == AND)      o_acc_op = ACC_AND;
				else if (opcode == TAD) o_acc_op = ACC_TAD;
			end
			S_WRITE:  if (opcode == DCA) o_acc_op = ACC_CLEAR;
			default: ;
		endcase
	end

	// ************************************************************
	// State and PC
	// ************************************************************
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state_q <= S_HALT;
			pc_q    <= RESET_PC;
		end else begin
			case (state_q)
				S_HALT: begin
					if (i_start) begin
						pc_q    <= i_start_pc;
						state_q <= S_FETCH;
					end
				end
				S_FETCH: state_q <= S_DECODE;
				S_DECODE: begin
					if (opcode == OPR) begin
						pc_q    <= i_skip ? pc_skip : pc_inc;
						state_q <= i_halt_req ? S_HALT : S_FETCH;
					end else if (opcode == IOT) begin
						pc_q    <= pc_inc;         // No devices, plain no-op
						state_q <= S_FETCH;
					end else if (cur_ir[BIT_INDIRECT]) begin
						state_q <= S_DEFER;
					end else begin
						if (opcode == JMP) pc_q <= ea_direct;
						state_q <= after_ea;
					end
				end
				S_DEFER: begin
					if (opcode == JMP) pc_q <= i_rdata;  // Pointer is the target
					state_q <= after_ea;
				end
				S_READ: state_q <= S_EXEC;
				S_EXEC: begin
					if (opcode == ISZ) begin
						state_q <= S_WRITE;
					end else begin
						pc_q    <= pc_inc;         // AND, TAD done
						state_q <= S_FETCH;
					end
				end
				S_WRITE: begin
					case (opcode)
						JMS:     pc_q <= ea_q + 12'd1;
						ISZ:     pc_q <= (isz_q == '0) ? pc_skip : pc_inc;
						default: pc_q <= pc_inc;
					endcase
					state_q <= S_FETCH;
				end
				default: state_q <= S_HALT;
			endcase
		end
	end

	// Instruction and address registers
	always_ff @(posedge i_clk) begin
		if (state_q == S_DECODE) begin
			ir_q <= i_rdata;
			ea_q <= ea_direct;
		end
		if (state_q == S_DEFER) ea_q <= i_rdata;   // Indirect target
		if (state_q == S_EXEC) isz_q <= i_rdata + 12'd1;
	end

	assign o_operand = i_rdata;
	assign o_ir      = cur_ir;
	assign o_halted  = (state_q == S_HALT);
	assign o_pc      = pc_q;

endmodule

`default_nettype wire
